//--- all.f
hdl/parity_pkg.sv
hdl/dataint_parity.sv
hdl/parity_ram.sv
hdl/scrub_timer.sv
hdl/scrub_fsm.sv
hdl/error_log.sv
hdl/parity_mem_top.sv
test/tb_parity_mem.sv

//--- run.sh
#!/bin/sh
# Compile and run the parity memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_parity_mem -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi

//--- test/tb_parity_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_parity_mem
        import parity_pkg::*;
();

        localparam int SCRUB_INTERVAL = 200;
        localparam int DEPTH          = 16;

        // Expected response of one host read
        typedef struct packed {
                logic [ADDR_W-1:0]     addr;
                logic [DATA_W-1:0]     data;
                logic [PAR_CHUNKS-1:0] par;
                logic [PAR_CHUNKS-1:0] err;
                // Cycle in which rd_en was driven
                logic [31:0]           cyc;
        } read_exp_t;

        logic                  clk;
        logic                  rst;
        logic                  wr_en;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
        logic [PAR_CHUNKS-1:0] inject_mask;
        logic                  rd_en;
        logic                  parity_type;
        logic                  rd_valid;
        logic [DATA_W-1:0]     rdata;
        logic [PAR_CHUNKS-1:0] rd_parity;
        logic [PAR_CHUNKS-1:0] rd_err;
        logic [7:0]            err_count;
        logic [ADDR_W-1:0]     first_err_addr;
        logic                  first_err_valid;
        logic                  scrub_done;

        // Shadow of the stored words
        logic [DATA_W-1:0]     sh_data [DEPTH];
        logic [PAR_CHUNKS-1:0] sh_mask [DEPTH];
        logic                  sh_type [DEPTH];

        read_exp_t   exp_q[$];
        logic [31:0] cyc;
        logic [31:0] rng_state;
        int          scrub_passes;

        parity_mem_top #(
                .SCRUB_INTERVAL (SCRUB_INTERVAL),
                .DEPTH          (DEPTH)
        ) DUT (
                .clk             (clk),
                .rst             (rst),
                .wr_en           (wr_en),
                .addr            (addr),
                .wdata           (wdata),
                .inject_mask     (inject_mask),
                .rd_en           (rd_en),
                .parity_type     (parity_type),
                .rd_valid        (rd_valid),
                .rdata           (rdata),
                .rd_parity       (rd_parity),
                .rd_err          (rd_err),
                .err_count       (err_count),
                .first_err_addr  (first_err_addr),
                .first_err_valid (first_err_valid),
                .scrub_done      (scrub_done)
        );

        // ----------------------------------------
        // Clock, cycle count, helpers
        // ----------------------------------------

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk) begin
                if (rst) begin
                        cyc <= '0;
                end else begin
                        cyc <= cyc + 32'd1;
                end
        end

        // Count finished scrub passes
        always @(negedge clk) begin
                if (rst) begin
                        scrub_passes <= 0;
                end else if (scrub_done) begin
                        scrub_passes <= scrub_passes + 1;
                end
        end

        // 32-bit xorshift step
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // Chunk parities for even (1) or odd (0) parity type
        function automatic logic [PAR_CHUNKS-1:0] ref_parity(input logic [DATA_W-1:0] data,
                                                              input logic ptype);
                logic [PAR_CHUNKS-1:0] p;
                for (int i = 0; i < PAR_CHUNKS; i++) begin
                        // Even parity bit makes the chunk's ones count even
                        p[i] = ^data[i*8 +: 8];
                        if (!ptype) begin
                                p[i] = ~p[i];
                        end
                end
                return p;
        endfunction

        task automatic stop_run();
                $display("Finished with errors");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic host_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                                  input logic [PAR_CHUNKS-1:0] m);
                @(posedge clk);
                #1;
                wr_en       = 1'b1;
                rd_en       = 1'b0;
                addr        = a;
                wdata       = d;
                inject_mask = m;
                sh_data[a]  = d;
                sh_mask[a]  = m;
                sh_type[a]  = parity_type;
        endtask

        task automatic host_read(input logic [ADDR_W-1:0] a);
                read_exp_t e;
                @(posedge clk);
                #1;
                wr_en  = 1'b0;
                rd_en  = 1'b1;
                addr   = a;
                e.addr = a;
                e.data = sh_data[a];
                // Stored bits carry the write-time parity and the mask
                e.par  = ref_parity(sh_data[a], sh_type[a]) ^ sh_mask[a];
                e.err  = ref_parity(sh_data[a], parity_type) ^ e.par;
                e.cyc  = cyc;
                exp_q.push_back(e);
        endtask

        task automatic idle_cycle();
                @(posedge clk);
                #1;
                wr_en = 1'b0;
                rd_en = 1'b0;
        endtask

        task automatic wait_reads_drained(input int limit);
                int n;
                n = 0;
                while (exp_q.size() != 0) begin
                        @(posedge clk);
                        n++;
                        if (n > limit) begin
                                $display("Timeout: host reads still outstanding after %0d cycles",
                                         limit);
                                stop_run();
                        end
                end
        endtask

        task automatic wait_scrub_passes(input int target, input int limit);
                int n;
                n = 0;
                while (scrub_passes < target) begin
                        @(posedge clk);
                        n++;
                        if (n > limit) begin
                                $display("Timeout: scrub pass %0d did not finish in %0d cycles",
                                         target, limit);
                                stop_run();
                        end
                end
        endtask

        // ----------------------------------------
        // Read response checker
        // ----------------------------------------

        always @(negedge clk) begin : check_reads
                read_exp_t want;
                if (!rst) begin
                        if (rd_valid) begin
                                assert (exp_q.size() != 0) else begin
                                        $display("rd_valid at %0t with no host read pending", $time);
                                        stop_run();
                                end
                                want = exp_q.pop_front();
                                // Two cycles from rd_en to rd_valid
                                assert (cyc == want.cyc + 32'd2) else begin
                                        $display("[FAIL] %0t addr %0d latency %0d expected 2",
                                                 $time, want.addr, cyc - want.cyc);
                                        stop_run();
                                end
                                assert (rdata == want.data) else begin
                                        $display("[FAIL] %0t addr %0d rdata %h expected %h",
                                                 $time, want.addr, rdata, want.data);
                                        stop_run();
                                end
                                assert (rd_parity == want.par) else begin
                                        $display("[FAIL] %0t addr %0d rd_parity %b expected %b",
                                                 $time, want.addr, rd_parity, want.par);
                                        stop_run();
                                end
                                assert (rd_err == want.err) else begin
                                        $display("[FAIL] %0t addr %0d rd_err %b expected %b",
                                                 $time, want.addr, rd_err, want.err);
                                        stop_run();
                                end
                        end else if (exp_q.size() != 0 && cyc >= exp_q[0].cyc + 32'd2) begin
                                $display("Host read of address %0d got no rd_valid", exp_q[0].addr);
                                stop_run();
                        end
                end
        end

        // ----------------------------------------
        // Stimulus sequence
        // ----------------------------------------

        initial begin : main
                logic [ADDR_W-1:0] first_bad;
                logic              any_bad;
                int                n_bad;

                rst         = 1'b1;
                wr_en       = 1'b0;
                rd_en       = 1'b0;
                addr        = '0;
                wdata       = '0;
                inject_mask = '0;
                parity_type = 1'b0;
                rng_state   = 32'd98;
                n_bad       = 0;
                any_bad     = 1'b0;
                first_bad   = '0;

                repeat (16) @(posedge clk);
                #1;
                rst = 1'b0;
                @(negedge clk);
                assert (!rd_valid && !scrub_done && !first_err_valid && err_count == 8'd0)
                else begin
                        $display("[FAIL] %0t outputs not cleared by reset", $time);
                        stop_run();
                end

                // Clean words under odd and then even parity
                for (int pt = 0; pt < 2; pt++) begin
                        @(posedge clk);
                        #1;
                        parity_type = pt[0];
                        for (int i = 0; i < DEPTH; i++) begin
                                rng_state = xorshift32(rng_state);
                                host_write(ADDR_W'(i), rng_state, '0);
                        end
                        for (int i = 0; i < DEPTH; i++) begin
                                host_read(ADDR_W'(i));
                        end
                        idle_cycle();
                        wait_reads_drained(10);
                end

                // Fault injection through random masks
                for (int i = 0; i < DEPTH; i++) begin
                        rng_state = xorshift32(rng_state);
                        host_write(ADDR_W'(i), rng_state, rng_state[7:4]);
                        if (rng_state[7:4] != '0) begin
                                if (!any_bad) begin
                                        first_bad = ADDR_W'(i);
                                end
                                any_bad = 1'b1;
                                n_bad++;
                        end
                end
                for (int i = 0; i < DEPTH; i++) begin
                        host_read(ADDR_W'(i));
                end
                idle_cycle();
                wait_reads_drained(10);

                // Mostly reads that span the first scrub pass
                for (int i = 0; i < 160; i++) begin
                        rng_state = xorshift32(rng_state);
                        if (rng_state[1:0] != 2'b00) begin
                                host_read(rng_state[11:8]);
                        end else begin
                                idle_cycle();
                        end
                end
                idle_cycle();
                wait_reads_drained(10);
                wait_scrub_passes(1, 400);
                @(negedge clk);
                assert (err_count == 8'(n_bad)) else begin
                        $display("[FAIL] %0t err_count %0d expected %0d", $time, err_count, n_bad);
                        stop_run();
                end
                assert (first_err_valid == any_bad && (!any_bad || first_err_addr == first_bad))
                else begin
                        $display("[FAIL] %0t first error valid %b addr %0d expected %b addr %0d",
                                 $time, first_err_valid, first_err_addr, any_bad, first_bad);
                        stop_run();
                end

                // Clean rewrite of the corrupted words
                for (int i = 0; i < DEPTH; i++) begin
                        if (sh_mask[i] != '0) begin
                                host_write(ADDR_W'(i), sh_data[i], '0);
                        end
                end
                for (int i = 0; i < DEPTH; i++) begin
                        host_read(ADDR_W'(i));
                end
                idle_cycle();
                wait_reads_drained(10);
                wait_scrub_passes(2, 600);
                @(negedge clk);
                assert (err_count == 8'(n_bad) && first_err_addr == first_bad) else begin
                        $display("[FAIL] %0t err_count %0d addr %0d expected %0d addr %0d",
                                 $time, err_count, first_err_addr, n_bad, first_bad);
                        stop_run();
                end

                $display("Finished with no errors");
                $finish;
        end

endmodule : tb_parity_mem

`default_nettype wire

//--- hdl/parity_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module parity_mem_top
        import parity_pkg::*;
#(
        parameter int SCRUB_INTERVAL = 200,
        parameter int DEPTH          = 16
) (
        input  logic                  clk,
        input  logic                  rst,
        // Host access
        input  logic                  wr_en,
        input  logic [ADDR_W-1:0]     addr,
        input  logic [DATA_W-1:0]     wdata,
        input  logic [PAR_CHUNKS-1:0] inject_mask,
        input  logic                  rd_en,
        // 1 even, 0 odd, static while data is held
        input  logic                  parity_type,
        // Host read return
        output logic                  rd_valid,
        output logic [DATA_W-1:0]     rdata,
        output logic [PAR_CHUNKS-1:0] rd_parity,
        output logic [PAR_CHUNKS-1:0] rd_err,
        // Error log
        output logic [7:0]            err_count,
        output logic [ADDR_W-1:0]     first_err_addr,
        output logic                  first_err_valid,
        output logic                  scrub_done
);

        logic [PAR_CHUNKS-1:0] gen_par;
        logic [PAR_CHUNKS-1:0] chunk_err;
        mem_word_t             wword;
        mem_word_t             rword;
        logic                  ram_re;
        logic [ADDR_W-1:0]     ram_raddr;
        logic                  scrub_due;
        logic                  res_valid;
        check_result_t         result;

        // ----------------------------------------
        // Write path with fault injection
        // ----------------------------------------

        dataint_parity #(
                .WIDTH  (DATA_W),
                .CHUNKS (PAR_CHUNKS)
        ) u_par_gen (
                .data_in     (wdata),
                .parity_in   ('0),
                .parity_type (parity_type),
                .parity      (gen_par),
                .parity_err  ()
        );

        // Mask flips stored parity bits on purpose
        assign wword.data = wdata;
        assign wword.par  = gen_par ^ inject_mask;

        parity_ram #(
                .DEPTH (DEPTH)
        ) u_ram (
                .clk   (clk),
                .we    (wr_en),
                .waddr (addr),
                .wword (wword),
                .re    (ram_re),
                .raddr (ram_raddr),
                .rword (rword)
        );

        // ----------------------------------------
        // Read check and scrub control
        // ----------------------------------------

        // Recompute parity of the read data against the stored bits
        dataint_parity #(
                .WIDTH  (DATA_W),
                .CHUNKS (PAR_CHUNKS)
        ) u_par_chk (
                .data_in     (rword.data),
                .parity_in   (rword.par),
                .parity_type (parity_type),
                .parity      (),
                .parity_err  (chunk_err)
        );

        scrub_timer #(
                .SCRUB_INTERVAL (SCRUB_INTERVAL)
        ) u_timer (
                .clk       (clk),
                .rst       (rst),
                .scrub_due (scrub_due)
        );

        scrub_fsm #(
                .DEPTH (DEPTH)
        ) u_fsm (
                .clk        (clk),
                .rst        (rst),
                .scrub_due  (scrub_due),
                .wr_en      (wr_en),
                .rd_en      (rd_en),
                .host_addr  (addr),
                .ram_re     (ram_re),
                .ram_raddr  (ram_raddr),
                .rword      (rword),
                .chunk_err  (chunk_err),
                .res_valid  (res_valid),
                .result     (result),
                .scrub_done (scrub_done)
        );

        error_log u_log (
                .clk             (clk),
                .rst             (rst),
                .res_valid       (res_valid),
                .result          (result),
                .err_count       (err_count),
                .first_err_addr  (first_err_addr),
                .first_err_valid (first_err_valid)
        );

        // Host results go out, scrub results stay internal
        assign rd_valid  = res_valid && !result.from_scrub;
        assign rdata     = result.data;
        assign rd_parity = result.par;
        assign rd_err    = result.chunk_err;

endmodule : parity_mem_top

`default_nettype wire

//--- hdl/error_log.sv
`timescale 1ns/1ps
`default_nettype none

module error_log
        import parity_pkg::*;
(
        input  logic              clk,
        input  logic              rst,
        input  logic              res_valid,
        input  check_result_t     result,
        output logic [7:0]        err_count,
        output logic [ADDR_W-1:0] first_err_addr,
        output logic              first_err_valid
);

        logic scrub_err;
        logic count_full;

        // Scrubbed word with at least one bad chunk, host results ignored
        assign scrub_err = res_valid && result.from_scrub && (|result.chunk_err);

        // Counter stops at its top value
        assign count_full = &err_count;

        // ----------------------------------------
        // Counter and first-error flag
        // ----------------------------------------

        always_ff @(posedge clk) begin
                if (rst) begin
                        err_count       <= '0;
                        first_err_valid <= 1'b0;
                end else begin
                        if (scrub_err && !count_full) begin
                                err_count <= err_count + 1'b1;
                        end
                        // Sticky until reset
                        if (scrub_err) begin
                                first_err_valid <= 1'b1;
                        end
                end
        end

        // Address capture, only the first failure since reset
        always_ff @(posedge clk) begin
                if (scrub_err && !first_err_valid) begin
                        first_err_addr <= result.addr;
                end
        end

endmodule : error_log

`default_nettype wire

//--- hdl/scrub_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module scrub_fsm
        import parity_pkg::*;
#(
        parameter int DEPTH = 16
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  scrub_due,
        // Host strobes that always win the read port
        input  logic                  wr_en,
        input  logic                  rd_en,
        input  logic [ADDR_W-1:0]     host_addr,
        // RAM read port
        output logic                  ram_re,
        output logic [ADDR_W-1:0]     ram_raddr,
        input  mem_word_t             rword,
        // Checker verdict for the current rword
        input  logic [PAR_CHUNKS-1:0] chunk_err,
        // Registered check result
        output logic                  res_valid,
        output check_result_t         result,
        output logic                  scrub_done
);

        typedef enum logic [1:0] {
                IDLE,
                SCAN,
                DONE
        } state_t;

        state_t state;
        state_t next_state;

        logic [ADDR_W-1:0] scrub_addr;
        logic              scrub_issue;
        logic              last_addr;
        logic              scrub_busy;

        // Stage 1 tag aligned with rword
        logic              s1_valid;
        logic              s1_scrub;
        logic [ADDR_W-1:0] s1_addr;

        // ----------------------------------------
        // Read port arbitration
        // ----------------------------------------

        // Scrub reads only fill idle host cycles
        assign scrub_issue = (state == SCAN) && !wr_en && !rd_en;
        assign ram_re      = rd_en || scrub_issue;
        assign ram_raddr   = rd_en ? host_addr : scrub_addr;

        assign last_addr = (scrub_addr == ADDR_W'(DEPTH - 1));

        // Scrub reads still travelling the tag pipeline
        assign scrub_busy = (s1_valid && s1_scrub) || (res_valid && result.from_scrub);

        // ----------------------------------------
        // Pass control
        // ----------------------------------------

        always_comb begin
                next_state = state;
                case (state)
                        // Start only from idle and drop due strobes mid-pass
                        IDLE: if (scrub_due) next_state = SCAN;
                        SCAN: if (scrub_issue && last_addr) next_state = DONE;
                        // Hold until the last verdict has reached the log
                        DONE: if (!scrub_busy) next_state = IDLE;
                        default: next_state = IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= IDLE;
                        scrub_addr <= '0;
                        scrub_done <= 1'b0;
                end else begin
                        state      <= next_state;
                        // Counter moves only on an issued scrub read
                        if (state == IDLE) begin
                                scrub_addr <= '0;
                        end else if (scrub_issue) begin
                                scrub_addr <= scrub_addr + 1'b1;
                        end
                        scrub_done <= (state == DONE) && !scrub_busy;
                end
        end

        // ----------------------------------------
        // Tag pipeline and result register
        // ----------------------------------------

        always_ff @(posedge clk) begin
                if (rst) begin
                        s1_valid  <= 1'b0;
                        res_valid <= 1'b0;
                end else begin
                        s1_valid  <= ram_re;
                        res_valid <= s1_valid;
                end
        end

        // Payload travels alongside the valid bits
        always_ff @(posedge clk) begin
                s1_scrub          <= scrub_issue;
                s1_addr           <= ram_raddr;
                result.addr       <= s1_addr;
                result.data       <= rword.data;
                result.par        <= rword.par;
                result.chunk_err  <= chunk_err;
                result.from_scrub <= s1_scrub;
        end

        // Every host read enters the pipeline next cycle as a host tag
        a_host_read_kept: assert property (
                @(posedge clk) disable iff (rst)
                rd_en |=> (s1_valid && !s1_scrub && s1_addr == $past(host_addr))
        ) else $error("host read lost or displaced by a scrub read");

        // End-of-pass pulse leaves DONE two cycles after the last address verdict
        a_done_in_done: assert property (
                @(posedge clk) disable iff (rst)
                scrub_done |-> $past(state == DONE) &&
                        $past(res_valid && result.from_scrub &&
                              result.addr == ADDR_W'(DEPTH - 1), 2)
        ) else $error("scrub_done outside DONE or before the last scrub verdict");

endmodule : scrub_fsm

`default_nettype wire

//--- hdl/scrub_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scrub_timer #(
        parameter int SCRUB_INTERVAL = 200
) (
        input  logic clk,
        input  logic rst,
        output logic scrub_due
);

        // Counter wide enough for the terminal value
        localparam int CNT_W = $clog2(SCRUB_INTERVAL + 1);

        logic [CNT_W-1:0] cnt;
        logic             at_end;

        // Terminal count of one interval
        assign at_end = (cnt == CNT_W'(SCRUB_INTERVAL - 1));

        // Free-running interval counter
        always_ff @(posedge clk) begin
                if (rst) begin
                        cnt       <= '0;
                        scrub_due <= 1'b0;
                end else begin
                        // Wrap and restart the interval
                        cnt       <= at_end ? '0 : cnt + 1'b1;
                        // One-cycle strobe per interval
                        scrub_due <= at_end;
                end
        end

        // Strobe is a single-cycle pulse
        a_due_pulse: assert property (
                @(posedge clk) disable iff (rst) scrub_due |=> !scrub_due
        ) else $error("scrub_due held high for two cycles");

endmodule : scrub_timer

`default_nettype wire

//--- hdl/parity_ram.sv
`timescale 1ns/1ps
`default_nettype none

module parity_ram
        import parity_pkg::*;
#(
        parameter int DEPTH = 16
) (
        input  logic              clk,
        // Write port
        input  logic              we,
        input  logic [ADDR_W-1:0] waddr,
        input  mem_word_t         wword,
        // Read port, data one cycle after re
        input  logic              re,
        input  logic [ADDR_W-1:0] raddr,
        output mem_word_t         rword
);

        // Word array, contents undefined until written
        mem_word_t mem [DEPTH];

        // ----------------------------------------
        // Write side
        // ----------------------------------------

        always_ff @(posedge clk) begin
                if (we) begin
                        mem[waddr] <= wword;
                end
        end

        // ----------------------------------------
        // Registered read
        // ----------------------------------------

        // Same-address write and read returns the old word
        always_ff @(posedge clk) begin
                if (re) begin
                        rword <= mem[raddr];
                end
        end

        // Host and scrub addresses must stay inside the populated range
        a_waddr_in_range: assert property (
                @(posedge clk) we |-> (int'(waddr) < DEPTH)
        ) else $error("parity_ram write address %0d out of range", waddr);

        a_raddr_in_range: assert property (
                @(posedge clk) re |-> (int'(raddr) < DEPTH)
        ) else $error("parity_ram read address %0d out of range", raddr);

endmodule : parity_ram

`default_nettype wire

//--- hdl/dataint_parity.sv
`timescale 1ns/1ps
`default_nettype none

module dataint_parity #(
        parameter int WIDTH  = 32,
        parameter int CHUNKS = 4
) (
        input  logic [WIDTH-1:0]  data_in,
        // Stored parity, only meaningful in checker use
        input  logic [CHUNKS-1:0] parity_in,
        // 1 selects even parity, 0 selects odd
        input  logic              parity_type,
        output logic [CHUNKS-1:0] parity,
        output logic [CHUNKS-1:0] parity_err
);

        // Nominal slice width
        localparam int SLICE_W = WIDTH / CHUNKS;

        genvar i;
        generate
                for (i = 0; i < CHUNKS; i++) begin : gen_chunk
                        // Slice bounds, last slice absorbs the remainder bits
                        localparam int LO = i * SLICE_W;
                        localparam int HI = (i == CHUNKS - 1) ? WIDTH - 1 : LO + SLICE_W - 1;

                        logic slice_xor;

                        // Plain XOR reduction of this slice
                        assign slice_xor = ^data_in[HI:LO];

                        // Even parity bit is the XOR itself, odd parity its inverse
                        assign parity[i] = parity_type ? slice_xor : ~slice_xor;

                        // Mismatch against the incoming parity bit
                        assign parity_err[i] = parity[i] ^ parity_in[i];
                end
        endgenerate

endmodule : dataint_parity

`default_nettype wire

//--- hdl/parity_pkg.sv
`default_nettype none

package parity_pkg;

        // ----------------------------------------
        // Word geometry
        // ----------------------------------------

        // Host data word width
        localparam int DATA_W = 32;

        // One parity bit per 8-bit chunk
        localparam int PAR_CHUNKS = 4;

        // Word address width, 16 words
        localparam int ADDR_W = 4;

        // ----------------------------------------
        // Shared records
        // ----------------------------------------

        // Stored memory entry, data with its chunk parity
        typedef struct packed {
                logic [DATA_W-1:0]     data;
                logic [PAR_CHUNKS-1:0] par;
        } mem_word_t;

        // Registered check verdict for one read
        typedef struct packed {
                logic [ADDR_W-1:0]     addr;
                logic [DATA_W-1:0]     data;
                logic [PAR_CHUNKS-1:0] par;
                // Set per chunk where stored and recomputed parity disagree
                logic [PAR_CHUNKS-1:0] chunk_err;
                // 1 for a scrub read, 0 for a host read
                logic                  from_scrub;
        } check_result_t;

endpackage : parity_pkg

`default_nettype wire
